// ==== all.f ====
source/conv_row_pkg.sv
source/row_fetch_if.sv
source/conv_loop_sequencer.sv
source/row_addr_translator.sv
source/row_buffer_bank.sv
source/conv_row_fetch_top.sv
test/conv_clock_gen.sv
test/conv_row_fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the row-fetch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

top=conv_row_fetch_tb
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" \
  -f all.f \
  -o "$top"

./obj_dir/"$top" | tee "$log"

if grep -q "Simulation FAILED" "$log"; then
  echo "run_sim: testbench reported failure, see $log"
  exit 1
fi

echo "run_sim: no failure in $log"
exit 0

// ==== source/conv_loop_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_loop_sequencer
  import conv_row_pkg::*;
#(
  parameter int credits_max = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             credit_return,
  input  logic [3:0]       s_init,
  input  logic [3:0]       p_init,
  input  logic [3:0]       nif_in_2pow_init,
  input  logic [adr_w-1:0] k_size,
  input  logic [adr_w-1:0] out_rows,
  output logic             done,
  row_fetch_if.seq         fetch
);

  localparam int cred_w = $clog2(credits_max + 1);
  // issue to out_valid, translator plus bank
  localparam int fetch_lat = 4;

  // config, sampled while reset is high
  logic [3:0]              s;
  logic [3:0]              p;
  logic [adr_w-1:0]        n_words;
  logic [adr_w-1:0]        k_last;
  logic [adr_w-1:0]        o_last;

  // loop state
  logic                    running;
  logic [adr_w-1:0]        o_cnt;
  logic [adr_w-1:0]        ky_cnt;
  logic [adr_w-1:0]        if_cnt;
  logic [adr_w-1:0]        iy_start;
  logic [adr_w-1:0]        base_in_3s;
  // lowest window row minus one, minus three per base step
  logic signed [adr_w-1:0] ahead;
  logic signed [adr_w-1:0] ahead_first;
  logic signed [adr_w-1:0] ahead_adv;
  logic [2:0]              tri_first;
  logic [2:0]              tri_adv;

  logic [cred_w-1:0]       credits;
  logic                    issue;
  logic                    last_if;
  logic                    last_ky;
  logic                    last_o;
  logic                    draining;
  logic [2:0]              drain_cnt;

  // whole triples held in a small non-negative distance
  function automatic logic [2:0] triples(input logic signed [adr_w-1:0] v);
    logic [2:0] t;
    t = 3'd0;
    for (int i = 1; i <= 5; i++) begin
      if (v >= signed'(adr_w'(buf_num * i))) t = 3'(i);
    end
    return t;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      s       <= s_init;
      p       <= p_init;
      n_words <= adr_w'(1) << nif_in_2pow_init;
      k_last  <= k_size - 1'b1;
      o_last  <= out_rows - 1'b1;
    end
  end

  // only issue while a credit is held
  assign issue   = running && (credits != '0);
  assign last_if = (if_cnt == n_words);
  assign last_ky = (ky_cnt == k_last);
  assign last_o  = (o_cnt == o_last);

  // first row of output row 0 is s - p, below 1 means padding
  assign ahead_first = signed'(adr_w'(s)) - signed'(adr_w'(p)) - signed'(adr_w'(1));
  assign ahead_adv   = ahead + signed'(adr_w'(s));
  assign tri_first   = triples(ahead_first);
  assign tri_adv     = triples(ahead_adv);

  //////////////////////////////////////////////////
  // loop counters, innermost is the feature word
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      running    <= 1'b0;
      o_cnt      <= '0;
      ky_cnt     <= '0;
      if_cnt     <= adr_w'(1);
      iy_start   <= '0;
      base_in_3s <= '0;
      ahead      <= '0;
    end else if (start && !running && !draining) begin
      running    <= 1'b1;
      o_cnt      <= '0;
      ky_cnt     <= '0;
      if_cnt     <= adr_w'(1);
      iy_start   <= '0;
      base_in_3s <= adr_w'(tri_first);
      ahead      <= ahead_first - signed'(adr_w'(buf_num * tri_first));
    end else if (issue) begin
      if (!last_if) begin
        if_cnt <= if_cnt + 1'b1;
      end else begin
        if_cnt <= adr_w'(1);
        if (!last_ky) begin
          ky_cnt <= ky_cnt + 1'b1;
        end else begin
          ky_cnt <= '0;
          if (last_o) begin
            running <= 1'b0;
          end else begin
            // next output row, window moves down by the stride
            o_cnt      <= o_cnt + 1'b1;
            iy_start   <= iy_start + adr_w'(s);
            base_in_3s <= base_in_3s + adr_w'(tri_adv);
            ahead      <= ahead_adv - signed'(adr_w'(buf_num * tri_adv));
          end
        end
      end
    end
  end

  // one credit per issue, one back per returned output
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= cred_w'(credits_max);
    end else begin
      credits <= credits - cred_w'(issue) + cred_w'(credit_return);
    end
  end

  // done follows the last out_valid by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      draining  <= 1'b0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (issue && last_if && last_ky && last_o) begin
        draining  <= 1'b1;
        drain_cnt <= '0;
      end else if (draining) begin
        if (drain_cnt == 3'(fetch_lat - 1)) begin
          draining <= 1'b0;
          done     <= 1'b1;
        end else begin
          drain_cnt <= drain_cnt + 1'b1;
        end
      end
    end
  end

  assign fetch.valid          = issue;
  assign fetch.ky             = ky_cnt;
  assign fetch.iy_start       = iy_start;
  assign fetch.row_base_in_3s = base_in_3s;
  assign fetch.if_start       = if_cnt;
  // whole row held as one segment
  assign fetch.row_start_idx  = '0;

endmodule

`default_nettype wire

// ==== source/conv_row_fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_row_fetch_top
  import conv_row_pkg::*;
#(
  parameter int pixels_in_row_2pow = 5,
  parameter int ifs_in_row_2pow    = 1,
  parameter int buffer_size_2pow   = 10,
  parameter int credits_max        = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [3:0]       s_init,
  input  logic [3:0]       p_init,
  input  logic [adr_w-1:0] iy_init,
  input  logic [3:0]       nif_in_2pow_init,
  input  logic [3:0]       ix_in_2pow_init,
  input  logic [adr_w-1:0] k_size,
  input  logic [adr_w-1:0] out_rows,
  input  logic             credit_return,
  input  logic             load_en,
  input  logic [1:0]       load_buf,
  input  logic [adr_w-1:0] load_adr,
  input  row_word_t        load_word,
  output logic             out_valid,
  output half_t            out_data,
  output logic             out_pad,
  output logic             done
);

  // translator to bank
  logic             row_valid;
  logic [adr_w-1:0] row_idx;
  logic [1:0]       buf_idx;
  logic [adr_w-1:0] buf_adr;
  logic             word_select;

  row_fetch_if fetch ();

  //////////////////////////////////////////////////
  // sequencer, translator, buffer bank
  //////////////////////////////////////////////////

  conv_loop_sequencer #(
    .credits_max (credits_max)
  ) u_seq (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .credit_return    (credit_return),
    .s_init           (s_init),
    .p_init           (p_init),
    .nif_in_2pow_init (nif_in_2pow_init),
    .k_size           (k_size),
    .out_rows         (out_rows),
    .done             (done),
    .fetch            (fetch.seq)
  );

  row_addr_translator #(
    .pixels_in_row_2pow (pixels_in_row_2pow),
    .ifs_in_row_2pow    (ifs_in_row_2pow),
    .buffer_size_2pow   (buffer_size_2pow)
  ) u_xlat (
    .clk              (clk),
    .reset            (reset),
    .s_init           (s_init),
    .p_init           (p_init),
    .iy_init          (iy_init),
    .nif_in_2pow_init (nif_in_2pow_init),
    .ix_in_2pow_init  (ix_in_2pow_init),
    .fetch            (fetch.xlat),
    .row_valid        (row_valid),
    .row_idx          (row_idx),
    .buf_idx          (buf_idx),
    .buf_adr          (buf_adr),
    .word_select      (word_select)
  );

  row_buffer_bank #(
    .buffer_size_2pow (buffer_size_2pow)
  ) u_bank (
    .clk         (clk),
    .reset       (reset),
    .load_en     (load_en),
    .load_buf    (load_buf),
    .load_adr    (load_adr),
    .load_word   (load_word),
    .row_valid   (row_valid),
    .word_select (word_select),
    .row_idx     (row_idx),
    .buf_adr     (buf_adr),
    .buf_idx     (buf_idx),
    .out_valid   (out_valid),
    .out_pad     (out_pad),
    .out_data    (out_data)
  );

endmodule

`default_nettype wire

// ==== source/conv_row_pkg.sv ====
`default_nettype none

package conv_row_pkg;

  //////////////////////////////////////////////////
  // widths and fixed buffer constants
  //////////////////////////////////////////////////

  // width of every row index, buffer address and loop counter
  localparam int adr_w = 16;

  // rows rotate over three buffers, one triple per base step
  localparam int buf_num = 3;

  // row index that marks a padding row
  localparam logic [adr_w-1:0] pad_idx = {adr_w{1'b1}};

  //////////////////////////////////////////////////
  // buffer word
  //////////////////////////////////////////////////

  // one feature half-word
  typedef logic [15:0] half_t;

  // loaded as one full word, read back as two halves
  typedef union packed {
    logic [31:0] word;
    struct packed {
      half_t hi;
      half_t lo;
    } halves;
  } row_word_t;

endpackage

`default_nettype wire

// ==== source/row_addr_translator.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_addr_translator
  import conv_row_pkg::*;
#(
  parameter int pixels_in_row_2pow = 5,
  parameter int ifs_in_row_2pow    = 1,
  parameter int buffer_size_2pow   = 10
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [3:0]       s_init,
  input  logic [3:0]       p_init,
  input  logic [adr_w-1:0] iy_init,
  input  logic [3:0]       nif_in_2pow_init,
  input  logic [3:0]       ix_in_2pow_init,
  row_fetch_if.xlat        fetch,
  output logic             row_valid,
  output logic [adr_w-1:0] row_idx,
  output logic [1:0]       buf_idx,
  output logic [adr_w-1:0] buf_adr,
  output logic             word_select
);

  // config, sampled while reset is high
  logic [3:0]       s;
  logic [3:0]       p;
  logic [adr_w-1:0] iy;
  // log2 of words per buffer row
  logic [3:0]       row_shift;
  logic [3:0]       row_shift_init;
  // log2 of words per feature group
  logic [3:0]       start_shift;
  // rows that fit into one buffer, as a power of two
  logic [3:0]       row_lim_init;
  logic [adr_w-1:0] row_mask;

  assign row_shift_init = nif_in_2pow_init + ix_in_2pow_init
                        - 4'(ifs_in_row_2pow + pixels_in_row_2pow);
  assign row_lim_init   = 4'(buffer_size_2pow) - row_shift_init;

  always_ff @(posedge clk) begin
    if (reset) begin
      s           <= s_init;
      p           <= p_init;
      iy          <= iy_init;
      row_shift   <= row_shift_init;
      start_shift <= nif_in_2pow_init - 4'(ifs_in_row_2pow);
      row_mask    <= ~({adr_w{1'b1}} << row_lim_init);
    end
  end

  //////////////////////////////////////////////////
  // stage 1: padded row index and bias
  //////////////////////////////////////////////////

  logic [adr_w-1:0] r_raw;
  logic [adr_w-1:0] r;
  logic [adr_w-1:0] p_ext;
  logic [adr_w-1:0] base3;
  logic             outside;
  logic             below;

  logic             valid_s1;
  logic [adr_w-1:0] row_idx_s1;
  logic [adr_w-1:0] bias_s1;
  logic [adr_w-1:0] base_s1;
  logic [adr_w-1:0] if_start_s1;
  logic [adr_w-1:0] row_start_s1;

  // r_raw is r + p, compares stay unsigned
  assign p_ext   = adr_w'(p);
  assign r_raw   = fetch.ky + fetch.iy_start + adr_w'(s);
  assign r       = r_raw - p_ext;
  assign base3   = fetch.row_base_in_3s * adr_w'(buf_num);
  // rows outside 1..iy are padding
  assign outside = (r_raw < p_ext + 1'b1) || (r_raw > p_ext + iy);
  // row sits at or below the base triple, step one triple back
  assign below   = (r_raw <= p_ext + base3);

  always_ff @(posedge clk) begin
    row_idx_s1   <= outside ? pad_idx : r;
    bias_s1      <= below ? r - base3 + adr_w'(buf_num) : r - base3;
    base_s1      <= below ? fetch.row_base_in_3s - 1'b1 : fetch.row_base_in_3s;
    if_start_s1  <= fetch.if_start;
    row_start_s1 <= fetch.row_start_idx;
  end

  //////////////////////////////////////////////////
  // stage 2: buffer index and row slot
  //////////////////////////////////////////////////

  logic [adr_w-1:0] lane;
  logic [1:0]       slot_off;
  logic             pad_s1;

  logic             valid_s2;
  logic [adr_w-1:0] row_idx_s2;
  logic [1:0]       buf_idx_s2;
  logic [adr_w-1:0] slot_s2;
  logic [adr_w-1:0] if_start_s2;
  logic [adr_w-1:0] row_start_s2;

  assign pad_s1 = (row_idx_s1 == pad_idx);

  // bias 1..12, four triples ahead of the base at most
  always_comb begin
    if (bias_s1 <= adr_w'(buf_num)) begin
      lane     = bias_s1 - 1'b1;
      slot_off = 2'd0;
    end else if (bias_s1 <= adr_w'(2 * buf_num)) begin
      lane     = bias_s1 - adr_w'(buf_num + 1);
      slot_off = 2'd1;
    end else if (bias_s1 <= adr_w'(3 * buf_num)) begin
      lane     = bias_s1 - adr_w'(2 * buf_num + 1);
      slot_off = 2'd2;
    end else begin
      lane     = bias_s1 - adr_w'(3 * buf_num + 1);
      slot_off = 2'd3;
    end
  end

  always_ff @(posedge clk) begin
    row_idx_s2   <= row_idx_s1;
    buf_idx_s2   <= pad_s1 ? 2'd0 : lane[1:0];
    slot_s2      <= pad_s1 ? '0 : base_s1 + adr_w'(slot_off);
    if_start_s2  <= if_start_s1;
    row_start_s2 <= row_start_s1;
  end

  //////////////////////////////////////////////////
  // stage 3: word address and half select
  //////////////////////////////////////////////////

  logic [adr_w-1:0] if_m1;
  logic             pad_s2;

  assign if_m1  = if_start_s2 - 1'b1;
  assign pad_s2 = (row_idx_s2 == pad_idx);

  always_ff @(posedge clk) begin
    row_idx     <= row_idx_s2;
    buf_idx     <= buf_idx_s2;
    // slot wraps at the buffer row limit
    buf_adr     <= pad_s2 ? pad_idx :
                   ((slot_s2 & row_mask) << row_shift)
                   + ((row_start_s2 << start_shift) >> pixels_in_row_2pow)
                   + (if_m1 >> ifs_in_row_2pow);
    word_select <= if_m1[0];
  end

  // valid runs alongside the three stages
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1  <= 1'b0;
      valid_s2  <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      valid_s1  <= fetch.valid;
      valid_s2  <= valid_s1;
      row_valid <= valid_s2;
    end
  end

endmodule

`default_nettype wire

// ==== source/row_buffer_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_buffer_bank
  import conv_row_pkg::*;
#(
  parameter int buffer_size_2pow = 10
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load_en,
  input  logic [1:0]       load_buf,
  input  logic [adr_w-1:0] load_adr,
  input  row_word_t        load_word,
  input  logic             row_valid,
  input  logic             word_select,
  input  logic [adr_w-1:0] row_idx,
  input  logic [adr_w-1:0] buf_adr,
  input  logic [1:0]       buf_idx,
  output logic             out_valid,
  output logic             out_pad,
  output half_t            out_data
);

  localparam int depth = 2 ** buffer_size_2pow;

  // three circular row buffers
  row_word_t                   mem [buf_num][depth];

  logic [buffer_size_2pow-1:0] wr_ptr;
  logic [buffer_size_2pow-1:0] rd_ptr;
  row_word_t                   rd_word;
  logic                        is_pad;

  // word address wraps inside one buffer
  assign wr_ptr  = load_adr[buffer_size_2pow-1:0];
  assign rd_ptr  = buf_adr[buffer_size_2pow-1:0];
  assign rd_word = mem[buf_idx][rd_ptr];
  assign is_pad  = (row_idx == pad_idx);

  //////////////////////////////////////////////////
  // load port, full word
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_buf][wr_ptr].word <= load_word.word;
    end
  end

  //////////////////////////////////////////////////
  // read path, one half per fetch
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= row_valid;
    end
  end

  // padding rows read as zero
  always_ff @(posedge clk) begin
    if (row_valid) begin
      out_pad <= is_pad;
      if (is_pad) begin
        out_data <= '0;
      end else if (word_select) begin
        out_data <= rd_word.halves.hi;
      end else begin
        out_data <= rd_word.halves.lo;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/row_fetch_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one fetch request from the loop sequencer to the address translator
// a request exists on every cycle with valid high, the translator never stalls
interface row_fetch_if
  import conv_row_pkg::*;
();

  logic             valid;
  // kernel row within the current output row
  logic [adr_w-1:0] ky;
  // first input row of the output row, o * s
  logic [adr_w-1:0] iy_start;
  // completed triples of buffer rows below the current window
  logic [adr_w-1:0] row_base_in_3s;
  // feature half-word counter, starts at 1
  logic [adr_w-1:0] if_start;
  // first pixel of the row segment
  logic [adr_w-1:0] row_start_idx;

  modport seq (
    output valid, ky, iy_start, row_base_in_3s, if_start, row_start_idx
  );

  modport xlat (
    input valid, ky, iy_start, row_base_in_3s, if_start, row_start_idx
  );

endinterface

`default_nettype wire

// ==== test/conv_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_clock_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset covers the first rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/conv_row_fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_row_fetch_tb
  import conv_row_pkg::*;
();

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////

  localparam int pixels_in_row_2pow = 5;
  localparam int ifs_in_row_2pow    = 1;
  localparam int buffer_size_2pow   = 10;
  localparam int credits_max        = 4;

  // stride 1, one padding row above and below
  localparam int cfg_s        = 1;
  localparam int cfg_p        = 1;
  localparam int cfg_iy       = 10;
  localparam int cfg_nif_2pow = 2;
  localparam int cfg_ix_2pow  = 5;
  localparam int cfg_k        = 3;
  localparam int cfg_out_rows = 10;

  localparam int depth          = 2 ** buffer_size_2pow;
  localparam int feat_words     = 2 ** cfg_nif_2pow;
  // log2 of words per buffer row
  localparam int row_words_2pow = cfg_nif_2pow + cfg_ix_2pow
                                - ifs_in_row_2pow - pixels_in_row_2pow;
  // rows one buffer holds before the slot wraps
  localparam int rows_in_buf    = 2 ** (buffer_size_2pow - row_words_2pow);
  localparam int total_fetches  = cfg_out_rows * cfg_k * feat_words;

  // timeouts and credit hold window
  localparam int idle_limit = 100;
  localparam int hold_at    = 40;
  localparam int hold_len   = 30;
  localparam int tail_len   = 10;

  logic             clk;
  logic             reset;
  logic             start;
  logic             credit_return;
  logic [3:0]       s_init;
  logic [3:0]       p_init;
  logic [adr_w-1:0] iy_init;
  logic [3:0]       nif_in_2pow_init;
  logic [3:0]       ix_in_2pow_init;
  logic [adr_w-1:0] k_size;
  logic [adr_w-1:0] out_rows;
  logic             load_en;
  logic [1:0]       load_buf;
  logic [adr_w-1:0] load_adr;
  row_word_t        load_word;
  logic             out_valid;
  half_t            out_data;
  logic             out_pad;
  logic             done;

  // expected outputs in loop order
  half_t exp_data [$];
  logic  exp_pad [$];

  integer seed;
  int errors = 0;
  int checks = 0;
  int received = 0;
  int returned = 0;
  // outputs consumed but whose credit is not yet back
  int pending = 0;
  int done_pulses = 0;
  int pad_seen = 0;
  int lo_seen = 0;
  int hi_seen = 0;

  conv_clock_gen #(
    .period_ns    (10),
    .reset_cycles (3)
  ) u_clk (
    .clk   (clk),
    .reset (reset)
  );

  conv_row_fetch_top #(
    .pixels_in_row_2pow (pixels_in_row_2pow),
    .ifs_in_row_2pow    (ifs_in_row_2pow),
    .buffer_size_2pow   (buffer_size_2pow),
    .credits_max        (credits_max)
  ) u_dut (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .s_init           (s_init),
    .p_init           (p_init),
    .iy_init          (iy_init),
    .nif_in_2pow_init (nif_in_2pow_init),
    .ix_in_2pow_init  (ix_in_2pow_init),
    .k_size           (k_size),
    .out_rows         (out_rows),
    .credit_return    (credit_return),
    .load_en          (load_en),
    .load_buf         (load_buf),
    .load_adr         (load_adr),
    .load_word        (load_word),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .out_pad          (out_pad),
    .done             (done)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  // half word tagged with buffer, half and full word address
  function automatic half_t pattern_half(input logic [1:0] b, input logic [9:0] a,
                                         input logic h);
    return {h, b, 3'b101, a};
  endfunction

  // row r lives in buffer (r-1) mod 3 at slot (r-1) div 3
  function automatic void build_expected();
    int r;
    int lane;
    int slot;
    int adr;
    for (int o = 0; o < cfg_out_rows; o++) begin
      for (int ky = 0; ky < cfg_k; ky++) begin
        for (int f = 1; f <= feat_words; f++) begin
          r = o * cfg_s + ky + cfg_s - cfg_p;
          if (r < 1 || r > cfg_iy) begin
            exp_pad.push_back(1'b1);
            exp_data.push_back('0);
          end else begin
            lane = (r - 1) % buf_num;
            slot = (r - 1) / buf_num;
            adr  = ((slot % rows_in_buf) << row_words_2pow)
                 + ((f - 1) >> ifs_in_row_2pow);
            exp_pad.push_back(1'b0);
            // odd feature word reads lo, even reads hi
            exp_data.push_back(pattern_half(2'(lane), 10'(adr % depth), 1'((f - 1) % 2)));
          end
        end
      end
    end
  endfunction

  // every word of every buffer, no output may appear meanwhile
  task automatic preload_buffers();
    for (int b = 0; b < buf_num; b++) begin
      for (int a = 0; a < depth; a++) begin
        @(negedge clk);
        load_en             = 1'b1;
        load_buf            = 2'(b);
        load_adr            = adr_w'(a);
        load_word.halves.hi = pattern_half(2'(b), 10'(a), 1'b1);
        load_word.halves.lo = pattern_half(2'(b), 10'(a), 1'b0);
        require(!out_valid && !done, "output activity during preload");
      end
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int wait_cycles;
    int idle;
    int hold_cycles;
    int idx;
    bit timed_out;
    bit finished;
    bit holding;

    seed             = 32'h6a54_c017;
    start            = 1'b0;
    credit_return    = 1'b0;
    load_en          = 1'b0;
    load_buf         = '0;
    load_adr         = '0;
    load_word        = '0;
    s_init           = 4'(cfg_s);
    p_init           = 4'(cfg_p);
    iy_init          = adr_w'(cfg_iy);
    nif_in_2pow_init = 4'(cfg_nif_2pow);
    ix_in_2pow_init  = 4'(cfg_ix_2pow);
    k_size           = adr_w'(cfg_k);
    out_rows         = adr_w'(cfg_out_rows);
    timed_out        = 1'b0;
    finished         = 1'b0;
    build_expected();

    wait_cycles = 0;
    while (reset !== 1'b0 && wait_cycles < 20) begin
      @(negedge clk);
      wait_cycles++;
    end
    require(reset === 1'b0, "reset was never released");

    if (reset === 1'b0) begin
      preload_buffers();
      repeat (5) begin
        @(negedge clk);
        require(!out_valid && !done, "output activity before start");
      end
      // one-cycle start pulse
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;

      idle        = 0;
      hold_cycles = 0;
      while (!finished && !timed_out) begin
        @(negedge clk);
        if (out_valid) begin
          idx = received;
          received++;
          idle = 0;
          if (idx >= total_fetches) begin
            require(1'b0, "more outputs than issued fetches");
          end else begin
            compare_value($sformatf("out_pad #%0d", idx), 32'(out_pad), 32'(exp_pad[idx]));
            compare_value($sformatf("out_data #%0d", idx), 32'(out_data), 32'(exp_data[idx]));
            // kinds of fetch the DUT delivered, bit 15 tags a hi half
            if (out_pad) begin
              pad_seen++;
            end else if (out_data[15]) begin
              hi_seen++;
            end else begin
              lo_seen++;
            end
          end
          require(received - returned <= credits_max, "outputs outstanding beyond credits");
          pending++;
        end else begin
          idle++;
        end

        if (done) begin
          done_pulses++;
          compare_value("outputs at done", received, total_fetches);
          finished = 1'b1;
        end else if (idle > idle_limit) begin
          require(1'b0, "no output for too many cycles, fetch stream stalled");
          timed_out = 1'b1;
        end

        // hold back credits for a while, the sequencer has to stop
        holding = (received >= hold_at) && (hold_cycles < hold_len);
        if (holding) begin
          hold_cycles++;
          if (hold_cycles == hold_len) begin
            require(received - returned == credits_max,
                    "output did not fill the credit window while credits were held");
          end
        end

        // random return schedule for consumed outputs
        if (!holding && pending > 0 && ($random(seed) & 3) != 0) begin
          credit_return = 1'b1;
          pending--;
          returned++;
        end else begin
          credit_return = 1'b0;
        end
      end

      credit_return = 1'b0;
      if (finished) begin
        repeat (tail_len) begin
          @(negedge clk);
          require(!out_valid, "output after done");
          if (done) done_pulses++;
        end
        compare_value("done pulses", done_pulses, 1);
        require(pad_seen > 0 && lo_seen > 0 && hi_seen > 0,
                "not every kind of fetch was reached");
      end
    end

    $display("checks %0d, errors %0d, outputs %0d of %0d, credits returned %0d",
             checks, errors, received, total_fetches, returned);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
